// ==== rtl/analyzer_regs_cfg.svh ====
`ifndef ANALYZER_REGS_CFG_SVH
`define ANALYZER_REGS_CFG_SVH

////////////////////
// Bus geometry
////////////////////

// Register offset = AXI address XOR base
`define BASE_ADDR           12'h000
`define ADDR_W              12
`define DATA_W              32

`define FILTER_WORDS        10
`define FRAME_BUF_AW        9

// The only AXI response code this block returns
`define RESP_OKAY           2'b00

////////////////////
// Constant words and reset values
////////////////////

`define REG_ID_VALUE        32'h0000_DA0A
`define REG_VERSION_VALUE   32'h0001_0200
`define FLIP_DEFAULT        32'h0000_0000
`define CONTROL_DEFAULT     32'h0000_0001
`define DEAD_WORD           32'hDEAD_BEEF

////////////////////
// Register map
////////////////////

`define REG_ID_ADDR             12'h000
`define REG_VERSION_ADDR        12'h004
`define REG_FLIP_ADDR           12'h008
`define REG_CONTROL_ADDR        12'h00C
`define REG_FILTER_DATA_ADDR    12'h010
`define REG_FILTER_MASK_ADDR    12'h040
// 64-bit items keep the high word here and the low word at +4
`define REG_PKTS_ADDR           12'h080
`define REG_OCTETS_ADDR         12'h088
`define REG_BAD_CRC_PKTS_ADDR   12'h090
`define REG_TESTFRAME_PKTS_ADDR 12'h098
`define REG_SEQ_ERRORS_ADDR     12'h0A0
`define REG_TS_SEC_ADDR         12'h0A8
`define REG_TS_NSEC_ADDR        12'h0B0
`define REG_FRAME_SIZE_ADDR     12'h0B4
`define REG_FRAME_BUF_ADDR      12'h0B8

`endif

// ==== rtl/analyzer_regs_pkg.sv ====
`include "analyzer_regs_cfg.svh"

package analyzer_regs_pkg;

    ////////////////////
    // Basic words
    ////////////////////

    typedef logic [`ADDR_W-1:0] reg_addr_t;
    typedef logic [`DATA_W-1:0] reg_data_t;

    ////////////////////
    // Internal requests
    ////////////////////

    // One cycle pulse per full-strobe write
    typedef struct packed {
        logic      valid;
        reg_addr_t offset;
        reg_data_t data;
    } wr_req_t;

    // Offset stays presented for the whole read
    typedef struct packed {
        logic      valid;
        reg_addr_t offset;
    } rd_req_t;

    // Forty octets of test-frame match pattern
    typedef reg_data_t [`FILTER_WORDS-1:0] filter_t;

    ////////////////////
    // Analyzer side
    ////////////////////

    typedef struct packed {
        logic [63:0] pkts;
        logic [63:0] octets;
        logic [63:0] bad_crc_pkts;
        logic [63:0] testframe_pkts;
        logic [63:0] seq_errors;
        logic [63:0] ts_sec;
        reg_data_t   ts_nsec;
        reg_data_t   frame_size;
    } analyzer_stats_t;

    ////////////////////
    // Channel FSMs
    ////////////////////

    typedef enum logic [1:0] {
        W_IDLE,
        W_ACCEPT,
        W_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ACCEPT,
        R_DATA
    } rd_state_e;

endpackage

// ==== rtl/axil_write_port.sv ====
`timescale 1ns/1ns
`include "analyzer_regs_cfg.svh"

module axil_write_port
    import analyzer_regs_pkg::*;
(
    input  logic       S_AXI_ACLK,
    input  logic       S_AXI_ARESETN,
    input  reg_addr_t  awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  reg_data_t  wdata,
    input  logic [3:0] wstrb,
    input  logic       wvalid,
    output logic       wready,
    output logic [1:0] bresp,
    output logic       bvalid,
    input  logic       bready,
    output wr_req_t    wr_req
);

    wr_state_e state;
    reg_addr_t offset_q;
    reg_data_t data_q;
    logic      strb_full_q;

    ////////////////////
    // Channel FSM
    ////////////////////

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: begin
                    // Address and data must both be present
                    if (awvalid && wvalid) begin
                        state <= W_ACCEPT;
                    end
                end
                W_ACCEPT: state <= W_RESP;
                W_RESP: begin
                    if (bready) begin
                        state <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    // Payload is held by the master, so sample it while idle
    always_ff @(posedge S_AXI_ACLK) begin
        if (state == W_IDLE) begin
            offset_q    <= awaddr ^ `BASE_ADDR;
            data_q      <= wdata;
            strb_full_q <= &wstrb;
        end
    end

    assign awready = (state == W_ACCEPT);
    assign wready  = (state == W_ACCEPT);
    assign bvalid  = (state == W_RESP);
    assign bresp   = `RESP_OKAY;

    // Partial strobes complete on the bus but never reach the registers
    assign wr_req.valid  = (state == W_ACCEPT) && strb_full_q;
    assign wr_req.offset = offset_q;
    assign wr_req.data   = data_q;

    // Readies only while the master still holds both channels
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (awready || wready) |-> (state == W_ACCEPT) && awvalid && wvalid);

endmodule

// ==== rtl/axil_read_port.sv ====
`timescale 1ns/1ns
`include "analyzer_regs_cfg.svh"

module axil_read_port
    import analyzer_regs_pkg::*;
(
    input  logic       S_AXI_ACLK,
    input  logic       S_AXI_ARESETN,
    input  reg_addr_t  araddr,
    input  logic       arvalid,
    output logic       arready,
    output reg_data_t  rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready,
    output rd_req_t    rd_req,
    input  reg_data_t  rd_data,
    output logic       rd_done
);

    rd_state_e state;
    reg_addr_t offset_q;

    ////////////////////
    // Channel FSM
    ////////////////////

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= R_IDLE;
        end else begin
            case (state)
                R_IDLE: begin
                    if (arvalid) begin
                        state <= R_ACCEPT;
                    end
                end
                R_ACCEPT: state <= R_DATA;
                R_DATA: begin
                    // Hold the word until the master takes it
                    if (rready) begin
                        state <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (state == R_IDLE) begin
            offset_q <= araddr ^ `BASE_ADDR;
        end
        // Decoded word captured at the end of the accept cycle
        if (state == R_ACCEPT) begin
            rdata <= rd_data;
        end
    end

    assign arready       = (state == R_ACCEPT);
    assign rvalid        = (state == R_DATA);
    assign rresp         = `RESP_OKAY;
    assign rd_req.valid  = (state == R_ACCEPT);
    assign rd_req.offset = offset_q;
    assign rd_done       = rvalid && rready;

    // Stalled read data must not move
    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (rvalid && !rready) |=> rvalid && $stable(rdata));

endmodule

// ==== rtl/ctrl_regs.sv ====
`timescale 1ns/1ns
`include "analyzer_regs_cfg.svh"

module ctrl_regs
    import analyzer_regs_pkg::*;
(
    input  logic      S_AXI_ACLK,
    input  logic      S_AXI_ARESETN,
    input  wr_req_t   wr_req,
    output reg_data_t cpu2ip_flip,
    output reg_data_t control,
    output filter_t   filter_data,
    output filter_t   filter_mask
);

    ////////////////////
    // Flip and control
    ////////////////////

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            cpu2ip_flip <= `FLIP_DEFAULT;
            control     <= `CONTROL_DEFAULT;
        end else if (wr_req.valid) begin
            case (wr_req.offset)
                `REG_FLIP_ADDR:    cpu2ip_flip <= wr_req.data;
                `REG_CONTROL_ADDR: control     <= wr_req.data;
                default: begin
                    // Not a single-word register
                end
            endcase
        end
    end

    ////////////////////
    // Test-frame filter
    ////////////////////

    // Data words start at 0x010 and mask words at 0x040, one word per offset
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            filter_data <= '0;
            filter_mask <= '0;
        end else if (wr_req.valid) begin
            for (int i = 0; i < `FILTER_WORDS; i++) begin
                if (wr_req.offset == reg_addr_t'(`REG_FILTER_DATA_ADDR + 4 * i)) begin
                    filter_data[i] <= wr_req.data;
                end
                if (wr_req.offset == reg_addr_t'(`REG_FILTER_MASK_ADDR + 4 * i)) begin
                    filter_mask[i] <= wr_req.data;
                end
            end
        end
    end

endmodule

// ==== rtl/stats_read_mux.sv ====
`timescale 1ns/1ns
`include "analyzer_regs_cfg.svh"

module stats_read_mux
    import analyzer_regs_pkg::*;
(
    input  logic                     S_AXI_ACLK,
    input  logic                     S_AXI_ARESETN,
    input  rd_req_t                  rd_req,
    input  logic                     rd_done,
    output reg_data_t                rd_data,
    input  reg_data_t                ip2cpu_flip,
    input  reg_data_t                control,
    input  filter_t                  filter_data,
    input  filter_t                  filter_mask,
    input  analyzer_stats_t          stats,
    input  reg_data_t                frame_buf_data,
    output logic [`FRAME_BUF_AW-1:0] frame_buf_address
);

    logic buf_inc_armed;

    ////////////////////
    // Read decode
    ////////////////////

    always_comb begin
        rd_data = `DEAD_WORD;
        case (rd_req.offset)
            `REG_ID_ADDR:                     rd_data = `REG_ID_VALUE;
            `REG_VERSION_ADDR:                rd_data = `REG_VERSION_VALUE;
            `REG_FLIP_ADDR:                   rd_data = ip2cpu_flip;
            `REG_CONTROL_ADDR:                rd_data = control;
            `REG_PKTS_ADDR:                   rd_data = stats.pkts[63:32];
            `REG_PKTS_ADDR + 12'h4:           rd_data = stats.pkts[31:0];
            `REG_OCTETS_ADDR:                 rd_data = stats.octets[63:32];
            `REG_OCTETS_ADDR + 12'h4:         rd_data = stats.octets[31:0];
            `REG_BAD_CRC_PKTS_ADDR:           rd_data = stats.bad_crc_pkts[63:32];
            `REG_BAD_CRC_PKTS_ADDR + 12'h4:   rd_data = stats.bad_crc_pkts[31:0];
            `REG_TESTFRAME_PKTS_ADDR:         rd_data = stats.testframe_pkts[63:32];
            `REG_TESTFRAME_PKTS_ADDR + 12'h4: rd_data = stats.testframe_pkts[31:0];
            `REG_SEQ_ERRORS_ADDR:             rd_data = stats.seq_errors[63:32];
            `REG_SEQ_ERRORS_ADDR + 12'h4:     rd_data = stats.seq_errors[31:0];
            `REG_TS_SEC_ADDR:                 rd_data = stats.ts_sec[63:32];
            `REG_TS_SEC_ADDR + 12'h4:         rd_data = stats.ts_sec[31:0];
            `REG_TS_NSEC_ADDR:                rd_data = stats.ts_nsec;
            `REG_FRAME_SIZE_ADDR:             rd_data = stats.frame_size;
            `REG_FRAME_BUF_ADDR:              rd_data = frame_buf_data;
            default: begin
                // Filter words are matched below
            end
        endcase
        for (int i = 0; i < `FILTER_WORDS; i++) begin
            if (rd_req.offset == reg_addr_t'(`REG_FILTER_DATA_ADDR + 4 * i)) begin
                rd_data = filter_data[i];
            end
            if (rd_req.offset == reg_addr_t'(`REG_FILTER_MASK_ADDR + 4 * i)) begin
                rd_data = filter_mask[i];
            end
        end
    end

    ////////////////////
    // Frame-buffer pointer
    ////////////////////

    // FRAME_SIZE rewinds and FRAME_BUF steps once its R beat completes
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            frame_buf_address <= '0;
            buf_inc_armed     <= 1'b0;
        end else if (rd_req.valid) begin
            if (rd_req.offset == `REG_FRAME_SIZE_ADDR) begin
                frame_buf_address <= '0;
                buf_inc_armed     <= 1'b0;
            end else if (rd_req.offset == `REG_FRAME_BUF_ADDR) begin
                buf_inc_armed <= 1'b1;
            end
        end else if (rd_done && buf_inc_armed) begin
            frame_buf_address <= frame_buf_address + 1'b1;
            buf_inc_armed     <= 1'b0;
        end
    end

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (!rd_req.valid && !rd_done) |=> $stable(frame_buf_address));

endmodule

// ==== rtl/traffic_analyzer_regs.sv ====
`timescale 1ns/1ns
`include "analyzer_regs_cfg.svh"

module traffic_analyzer_regs
    import analyzer_regs_pkg::*;
(
    input  logic                     S_AXI_ACLK,
    input  logic                     S_AXI_ARESETN,
    input  reg_addr_t                S_AXI_AWADDR,
    input  logic                     S_AXI_AWVALID,
    output logic                     S_AXI_AWREADY,
    input  reg_data_t                S_AXI_WDATA,
    input  logic [3:0]               S_AXI_WSTRB,
    input  logic                     S_AXI_WVALID,
    output logic                     S_AXI_WREADY,
    output logic [1:0]               S_AXI_BRESP,
    output logic                     S_AXI_BVALID,
    input  logic                     S_AXI_BREADY,
    input  reg_addr_t                S_AXI_ARADDR,
    input  logic                     S_AXI_ARVALID,
    output logic                     S_AXI_ARREADY,
    output reg_data_t                S_AXI_RDATA,
    output logic [1:0]               S_AXI_RRESP,
    output logic                     S_AXI_RVALID,
    input  logic                     S_AXI_RREADY,
    input  analyzer_stats_t          stats,
    input  reg_data_t                ip2cpu_flip,
    input  reg_data_t                frame_buf_data,
    output reg_data_t                cpu2ip_flip,
    output reg_data_t                control,
    output filter_t                  filter_data,
    output filter_t                  filter_mask,
    output logic [`FRAME_BUF_AW-1:0] frame_buf_address
);

    wr_req_t   wr_req;
    rd_req_t   rd_req;
    reg_data_t rd_data;
    logic      rd_done;

    ////////////////////
    // Write path
    ////////////////////

    axil_write_port u_wr_port (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .awaddr (S_AXI_AWADDR), .awvalid(S_AXI_AWVALID), .awready(S_AXI_AWREADY),
        .wdata  (S_AXI_WDATA),  .wstrb  (S_AXI_WSTRB),   .wvalid (S_AXI_WVALID),
        .wready (S_AXI_WREADY), .bresp  (S_AXI_BRESP),   .bvalid (S_AXI_BVALID),
        .bready (S_AXI_BREADY), .wr_req
    );

    ctrl_regs u_ctrl_regs (
        .S_AXI_ACLK, .S_AXI_ARESETN, .wr_req,
        .cpu2ip_flip, .control, .filter_data, .filter_mask
    );

    ////////////////////
    // Read path
    ////////////////////

    axil_read_port u_rd_port (
        .S_AXI_ACLK, .S_AXI_ARESETN,
        .araddr(S_AXI_ARADDR), .arvalid(S_AXI_ARVALID), .arready(S_AXI_ARREADY),
        .rdata (S_AXI_RDATA),  .rresp  (S_AXI_RRESP),   .rvalid (S_AXI_RVALID),
        .rready(S_AXI_RREADY), .rd_req, .rd_data, .rd_done
    );

    stats_read_mux u_read_mux (
        .S_AXI_ACLK, .S_AXI_ARESETN, .rd_req, .rd_done, .rd_data,
        .ip2cpu_flip, .control, .filter_data, .filter_mask,
        .stats, .frame_buf_data, .frame_buf_address
    );

endmodule

// ==== tests/tb_traffic_analyzer_regs.sv ====
`timescale 1ns/1ns
`include "analyzer_regs_cfg.svh"

module tb_traffic_analyzer_regs
    import analyzer_regs_pkg::*;
();

    localparam int CLK_PERIOD          = 100;
    localparam int DRIVE_DELAY         = 10;
    localparam int HANDSHAKE_LIMIT     = 16;
    // About 150 transfers of about 20 cycles each
    localparam int TRANSFER_BUDGET     = 150;
    localparam int CYCLES_PER_TRANSFER = 20;
    localparam int WATCHDOG_NS = TRANSFER_BUDGET * CYCLES_PER_TRANSFER * CLK_PERIOD;

    logic S_AXI_ACLK, S_AXI_ARESETN;
    reg_addr_t S_AXI_AWADDR, S_AXI_ARADDR;
    reg_data_t S_AXI_WDATA, S_AXI_RDATA;
    logic [3:0] S_AXI_WSTRB;
    logic S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
    logic [1:0] S_AXI_BRESP, S_AXI_RRESP;
    logic S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_ARREADY;
    logic S_AXI_RVALID, S_AXI_RREADY;
    analyzer_stats_t stats;
    reg_data_t ip2cpu_flip, frame_buf_data, cpu2ip_flip, control;
    filter_t filter_data, filter_mask;
    logic [`FRAME_BUF_AW-1:0] frame_buf_address;

    int mismatch_count = 0;
    int failure_count  = 0;
    logic [31:0] lfsr_state = 32'h3387;
    reg_data_t exp_flip, exp_ctrl;
    filter_t exp_data, exp_mask;

    traffic_analyzer_regs uut (.*);

    // Analyzer side returns the inverted flip word
    assign ip2cpu_flip = ~cpu2ip_flip;

    // Frame-buffer contents carry every address bit twice
    function automatic reg_data_t buf_entry(input logic [`FRAME_BUF_AW-1:0] a);
        return {7'h2A, a, 7'h15, ~a};
    endfunction

    assign frame_buf_data = buf_entry(frame_buf_address);

    ////////////////////
    // Helpers
    ////////////////////

    function automatic reg_data_t random_word();
        reg_data_t v;
        v = '0;
        for (int i = 0; i < 32; i++) begin
            // Galois step with taps x^32 + x^22 + x^2 + x + 1
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic reg_addr_t data_offset(input int i);
        return reg_addr_t'(`REG_FILTER_DATA_ADDR + 4 * i);
    endfunction

    function automatic reg_addr_t mask_offset(input int i);
        return reg_addr_t'(`REG_FILTER_MASK_ADDR + 4 * i);
    endfunction

    task automatic report_mismatch(input string what, input reg_data_t got, input reg_data_t exp);
        $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        mismatch_count++;
    endtask

    task automatic report_failure(input string what);
        $display("FAILURE at %0t ns: %s", $time, what);
        failure_count++;
    endtask

    task automatic check_outputs(input string when);
        if (cpu2ip_flip !== exp_flip)
            report_mismatch({"cpu2ip_flip ", when}, cpu2ip_flip, exp_flip);
        if (control !== exp_ctrl) report_mismatch({"control ", when}, control, exp_ctrl);
        for (int i = 0; i < `FILTER_WORDS; i++) begin
            if (filter_data[i] !== exp_data[i])
                report_mismatch($sformatf("filter_data[%0d] %s", i, when),
                                filter_data[i], exp_data[i]);
            if (filter_mask[i] !== exp_mask[i])
                report_mismatch($sformatf("filter_mask[%0d] %s", i, when),
                                filter_mask[i], exp_mask[i]);
        end
    endtask

    ////////////////////
    // Bus tasks
    ////////////////////

    task automatic axil_write(input reg_addr_t addr, input reg_data_t data,
                              input logic [3:0] strb, input int stall);
        int n;
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_AWADDR  = addr;
        S_AXI_WDATA   = data;
        S_AXI_WSTRB   = strb;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        n = 0;
        do begin
            @(negedge S_AXI_ACLK);
            n++;
        end while (!(S_AXI_AWREADY && S_AXI_WREADY) && n < HANDSHAKE_LIMIT);
        if (!(S_AXI_AWREADY && S_AXI_WREADY))
            report_failure($sformatf("write to %h was never accepted", addr));
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        for (int i = 0; i < stall; i++) begin
            @(negedge S_AXI_ACLK);
            if (!S_AXI_BVALID) report_failure("BVALID dropped while BREADY was low");
            @(posedge S_AXI_ACLK);
            #DRIVE_DELAY;
        end
        S_AXI_BREADY = 1'b1;
        n = 0;
        do begin
            @(negedge S_AXI_ACLK);
            n++;
        end while (!S_AXI_BVALID && n < HANDSHAKE_LIMIT);
        if (!S_AXI_BVALID) report_failure($sformatf("no write response for %h", addr));
        if (S_AXI_BRESP !== `RESP_OKAY) report_mismatch("BRESP", S_AXI_BRESP, `RESP_OKAY);
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic axil_read(input reg_addr_t addr, input int stall, output reg_data_t data);
        reg_data_t first_seen;
        int n;
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        n = 0;
        do begin
            @(negedge S_AXI_ACLK);
            n++;
        end while (!S_AXI_ARREADY && n < HANDSHAKE_LIMIT);
        if (!S_AXI_ARREADY) report_failure($sformatf("read of %h was never accepted", addr));
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_ARVALID = 1'b0;
        first_seen = S_AXI_RDATA;
        for (int i = 0; i < stall; i++) begin
            @(negedge S_AXI_ACLK);
            if (!S_AXI_RVALID) report_failure("RVALID dropped while RREADY was low");
            if (S_AXI_RDATA !== first_seen)
                report_mismatch("stalled RDATA", S_AXI_RDATA, first_seen);
            @(posedge S_AXI_ACLK);
            #DRIVE_DELAY;
        end
        S_AXI_RREADY = 1'b1;
        n = 0;
        do begin
            @(negedge S_AXI_ACLK);
            n++;
        end while (!S_AXI_RVALID && n < HANDSHAKE_LIMIT);
        if (!S_AXI_RVALID) report_failure($sformatf("no read data for %h", addr));
        if (S_AXI_RRESP !== `RESP_OKAY) report_mismatch("RRESP", S_AXI_RRESP, `RESP_OKAY);
        data = S_AXI_RDATA;
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_RREADY = 1'b0;
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic verify_reset_state();
        reg_data_t d;
        @(negedge S_AXI_ACLK);
        if (S_AXI_AWREADY || S_AXI_WREADY || S_AXI_BVALID || S_AXI_ARREADY || S_AXI_RVALID)
            report_failure("a handshake output is high after reset");
        if (frame_buf_address !== '0)
            report_mismatch("frame_buf_address after reset", frame_buf_address, 32'h0);
        exp_flip = `FLIP_DEFAULT;
        exp_ctrl = `CONTROL_DEFAULT;
        exp_data = '0;
        exp_mask = '0;
        check_outputs("after reset");
        axil_read(`REG_ID_ADDR, 0, d);
        if (d !== `REG_ID_VALUE) report_mismatch("ID", d, `REG_ID_VALUE);
        axil_read(`REG_VERSION_ADDR, 0, d);
        if (d !== `REG_VERSION_VALUE) report_mismatch("VERSION", d, `REG_VERSION_VALUE);
    endtask

    task automatic write_and_read_back();
        reg_data_t d;
        exp_flip = random_word();
        axil_write(`REG_FLIP_ADDR, exp_flip, 4'hF, 0);
        exp_ctrl = random_word();
        axil_write(`REG_CONTROL_ADDR, exp_ctrl, 4'hF, 1);
        for (int i = 0; i < `FILTER_WORDS; i++) begin
            exp_data[i] = random_word();
            axil_write(data_offset(i), exp_data[i], 4'hF, i % 3);
            exp_mask[i] = random_word();
            axil_write(mask_offset(i), exp_mask[i], 4'hF, (i + 1) % 3);
        end
        check_outputs("after full writes");
        axil_read(`REG_FLIP_ADDR, 0, d);
        if (d !== ~exp_flip) report_mismatch("FLIP read-back", d, ~exp_flip);
        axil_read(`REG_CONTROL_ADDR, 0, d);
        if (d !== exp_ctrl) report_mismatch("CONTROL read-back", d, exp_ctrl);
        for (int i = 0; i < `FILTER_WORDS; i++) begin
            axil_read(data_offset(i), i % 2, d);
            if (d !== exp_data[i])
                report_mismatch($sformatf("FILTER_DATA %0d", i), d, exp_data[i]);
            axil_read(mask_offset(i), 0, d);
            if (d !== exp_mask[i])
                report_mismatch($sformatf("FILTER_MASK %0d", i), d, exp_mask[i]);
        end
    endtask

    task automatic partial_strobe_writes();
        axil_write(`REG_FLIP_ADDR, random_word(), 4'b0111, 0);
        axil_write(`REG_CONTROL_ADDR, random_word(), 4'b0000, 2);
        axil_write(data_offset(2), random_word(), 4'b1110, 0);
        axil_write(mask_offset(9), random_word(), 4'b1011, 1);
        check_outputs("after partial-strobe writes");
    endtask

    task automatic read_counters();
        logic [63:0] wide [6];
        reg_data_t d;
        reg_addr_t unmapped [4] = '{12'h03C, 12'h068, 12'h0C0, 12'hFFC};
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        stats = {random_word(), random_word(), random_word(), random_word(),
                 random_word(), random_word(), random_word(), random_word(),
                 random_word(), random_word(), random_word(), random_word(),
                 random_word(), random_word()};
        wide = '{stats.pkts, stats.octets, stats.bad_crc_pkts,
                 stats.testframe_pkts, stats.seq_errors, stats.ts_sec};
        // Six 64-bit items at 8-byte spacing from PKTS
        for (int k = 0; k < 6; k++) begin
            axil_read(reg_addr_t'(`REG_PKTS_ADDR + 8 * k), k % 2, d);
            if (d !== wide[k][63:32])
                report_mismatch($sformatf("counter %0d high", k), d, wide[k][63:32]);
            axil_read(reg_addr_t'(`REG_PKTS_ADDR + 8 * k + 4), 0, d);
            if (d !== wide[k][31:0])
                report_mismatch($sformatf("counter %0d low", k), d, wide[k][31:0]);
        end
        axil_read(`REG_TS_NSEC_ADDR, 0, d);
        if (d !== stats.ts_nsec) report_mismatch("TS_NSEC", d, stats.ts_nsec);
        foreach (unmapped[j]) begin
            axil_read(unmapped[j], 0, d);
            if (d !== `DEAD_WORD)
                report_mismatch($sformatf("unmapped %h", unmapped[j]), d, `DEAD_WORD);
        end
    endtask

    task automatic walk_frame_buffer();
        reg_data_t d;
        axil_read(`REG_FRAME_SIZE_ADDR, 0, d);
        if (d !== stats.frame_size) report_mismatch("FRAME_SIZE", d, stats.frame_size);
        for (int i = 0; i < 6; i++) begin
            axil_read(`REG_FRAME_BUF_ADDR, i % 2, d);
            if (d !== buf_entry(i))
                report_mismatch($sformatf("FRAME_BUF entry %0d", i), d, buf_entry(i));
        end
        // Unrelated reads leave the pointer where it is
        axil_read(`REG_ID_ADDR, 0, d);
        axil_read(`REG_TS_NSEC_ADDR, 0, d);
        axil_read(`REG_FRAME_BUF_ADDR, 0, d);
        if (d !== buf_entry(6)) report_mismatch("FRAME_BUF entry 6", d, buf_entry(6));
        axil_read(`REG_FRAME_SIZE_ADDR, 0, d);
        for (int i = 0; i < 2; i++) begin
            axil_read(`REG_FRAME_BUF_ADDR, 0, d);
            if (d !== buf_entry(i))
                report_mismatch($sformatf("rewound entry %0d", i), d, buf_entry(i));
        end
        // Two completed FRAME_BUF reads since the rewind
        if (frame_buf_address !== 2)
            report_mismatch("frame_buf_address after rewind", frame_buf_address, 32'd2);
    endtask

    // Second AR arrives while the first R beat is stalled
    task automatic blocked_second_read();
        int n;
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_ARADDR  = `REG_ID_ADDR;
        S_AXI_ARVALID = 1'b1;
        n = 0;
        do begin
            @(negedge S_AXI_ACLK);
            n++;
        end while (!S_AXI_ARREADY && n < HANDSHAKE_LIMIT);
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_ARADDR = `REG_VERSION_ADDR;
        repeat (4) begin
            @(negedge S_AXI_ACLK);
            if (S_AXI_ARREADY) report_failure("second read accepted before the first completed");
            if (!S_AXI_RVALID) report_failure("RVALID dropped while RREADY was low");
        end
        if (S_AXI_RDATA !== `REG_ID_VALUE)
            report_mismatch("first stalled read", S_AXI_RDATA, `REG_ID_VALUE);
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_RREADY = 1'b1;
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_RREADY = 1'b0;
        n = 0;
        do begin
            @(negedge S_AXI_ACLK);
            n++;
        end while (!S_AXI_ARREADY && n < HANDSHAKE_LIMIT);
        if (!S_AXI_ARREADY) report_failure("second read was never accepted");
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b1;
        @(negedge S_AXI_ACLK);
        if (S_AXI_RDATA !== `REG_VERSION_VALUE)
            report_mismatch("second read", S_AXI_RDATA, `REG_VERSION_VALUE);
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_RREADY = 1'b0;
    endtask

    task automatic stall_responses();
        reg_data_t d;
        reg_data_t new_ctrl;
        exp_mask[3] = random_word();
        axil_write(mask_offset(3), exp_mask[3], 4'hF, 6);
        axil_read(mask_offset(3), 5, d);
        if (d !== exp_mask[3]) report_mismatch("stalled FILTER_MASK 3", d, exp_mask[3]);
        blocked_second_read();
        new_ctrl = random_word();
        fork
            axil_write(`REG_CONTROL_ADDR, new_ctrl, 4'hF, 3);
            axil_read(mask_offset(3), 4, d);
        join
        if (d !== exp_mask[3]) report_mismatch("read beside a write", d, exp_mask[3]);
        exp_ctrl = new_ctrl;
        check_outputs("after overlapped transfers");
    endtask

    ////////////////////
    // Clock, reset, sequence
    ////////////////////

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests completed");
        $display("test failed");
        $finish;
    end

    initial begin
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        stats         = '0;
        repeat (4) @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
        S_AXI_ARESETN = 1'b1;
        verify_reset_state();
        write_and_read_back();
        partial_strobe_writes();
        read_counters();
        walk_frame_buffer();
        stall_responses();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/analyzer_regs_pkg.sv
rtl/axil_write_port.sv
rtl/axil_read_port.sv
rtl/ctrl_regs.sv
rtl/stats_read_mux.sv
rtl/traffic_analyzer_regs.sv
tests/tb_traffic_analyzer_regs.sv
